//--- agp32.f
+incdir+.
agp32_pkg.sv
agp32_stage_if.sv
pipeline_control.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
agp32_core.sv
tb_clock.sv
agp32_core_tb.sv

//--- agp32_core.sv
`timescale 1ns/1ps
`include "agp32_params.svh"

module agp32_core (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    ready,
  input  logic                    mem_start_ready,
  input  logic [1:0]              error,
  input  logic [`AGP32_XLEN-1:0]  inst_rdata,
  input  logic [`AGP32_IN_W-1:0]  data_in,
  output agp32_pkg::command_e     command,
  output logic [`AGP32_XLEN-1:0]  pc,
  output logic [`AGP32_OUT_W-1:0] data_out
);
  import agp32_pkg::*;

  logic                      advance;
  logic                      flush;
  logic                      redirect;
  logic [`AGP32_XLEN-1:0]    redirect_pc;
  instr_u                    f_instr;
  logic [`AGP32_XLEN-1:0]    f_pc;
  logic                      f_valid;
  logic                      wb_en;
  logic [`AGP32_RADDR_W-1:0] wb_addr;
  logic [`AGP32_XLEN-1:0]    wb_data;

  agp32_stage_if u_stage_if ();

  pipeline_control u_control (
    .clk             (clk),
    .rst_n           (rst_n),
    .ready           (ready),
    .mem_start_ready (mem_start_ready),
    .error           (error),
    .redirect        (redirect),
    .command         (command),
    .advance         (advance),
    .flush           (flush)
  );

  fetch_stage u_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .advance     (advance),
    .flush       (flush),
    .ready       (ready),
    .inst_rdata  (inst_rdata),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .pc          (pc),
    .f_instr     (f_instr),
    .f_pc        (f_pc),
    .f_valid     (f_valid)
  );

  decode_stage u_decode (
    .clk     (clk),
    .rst_n   (rst_n),
    .advance (advance),
    .flush   (flush),
    .f_instr (f_instr),
    .f_pc    (f_pc),
    .f_valid (f_valid),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data),
    .stage   (u_stage_if.producer)
  );

  execute_stage u_execute (
    .clk         (clk),
    .rst_n       (rst_n),
    .advance     (advance),
    .data_in     (data_in),
    .stage       (u_stage_if.consumer),
    .wb_en       (wb_en),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .data_out    (data_out)
  );

endmodule

//--- agp32_core_tb.sv
`timescale 1ns/1ps
`include "agp32_params.svh"

module agp32_core_tb;
  import agp32_pkg::*;

  logic                    clk;
  logic                    rst_n;
  logic                    ready = 1'b1;
  logic                    mem_start_ready;
  logic [1:0]              error;
  logic [`AGP32_XLEN-1:0]  inst_rdata;
  logic [`AGP32_IN_W-1:0]  data_in;
  command_e                command;
  logic [`AGP32_XLEN-1:0]  pc;
  logic [`AGP32_OUT_W-1:0] data_out;

  logic [31:0] prog_mem [0:63];
  logic [31:0] prog_len;
  logic [31:0] mregs [0:63];
  logic [9:0]  exp_q [$];
  integer      seed = 89773;
  logic        random_ready;
  logic        timed_out;
  int          mismatches;
  int          other_errors;
  int          taken_count;
  int          restart_count = 0;
  int          restarts_seen;

  tb_clock u_clock (.clk(clk));

  agp32_core UUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .ready           (ready),
    .mem_start_ready (mem_start_ready),
    .error           (error),
    .inst_rdata      (inst_rdata),
    .data_in         (data_in),
    .command         (command),
    .pc              (pc),
    .data_out        (data_out)
  );

  // Instruction memory, bubbles past the end of the program
  assign inst_rdata = ({2'b00, pc[31:2]} < prog_len) ? prog_mem[pc[7:2]] : `AGP32_NOP_WORD;

  always @(negedge clk) begin
    if (random_ready) begin
      ready = (($random(seed) & 32'd3) != 32'd0);
    end else begin
      ready = 1'b1;
    end
  end

  always @(negedge clk) begin
    if (command == CMD_RESTART) begin
      restart_count <= restart_count + 1;
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      mismatches++;
    end
  endtask

  // ####################
  // Program building
  // ####################
  function automatic logic [31:0] enc_r(input logic [5:0] op, input logic [3:0] fn,
                                        input logic w_imm, input logic [5:0] w,
                                        input logic a_imm, input logic [5:0] a,
                                        input logic b_imm, input logic [5:0] b);
    return {w_imm, w, 1'b0, a_imm, a, b_imm, b, fn, op};
  endfunction

  function automatic logic [31:0] enc_ldi(input logic [5:0] w, input int value);
    logic [22:0] mag;
    mag = (value < 0) ? 23'(-value) : 23'(value);
    return {1'b1, w, 1'b1, value < 0, mag};
  endfunction

  function automatic logic [31:0] outr(input logic [3:0] fn, input logic [5:0] w,
                                       input logic [5:0] a, input logic [5:0] b);
    return enc_r(OP_OUT, fn, 1'b0, w, 1'b0, a, 1'b0, b);
  endfunction

  task automatic emit(input logic [31:0] word);
    prog_mem[prog_len[5:0]] = word;
    prog_len = prog_len + 32'd1;
  endtask

  task automatic load_arith_program();
    prog_len = 32'd0;
    emit(enc_ldi(6'd1, 8388607));
    emit(enc_ldi(6'd2, -5));
    emit(enc_ldi(6'd3, 100));
    emit(enc_ldi(6'd6, 256));
    emit(outr(FN_ADD, 6'd10, 6'd2, 6'd3));
    emit(outr(FN_CARRY, 6'd11, 6'd0, 6'd0));
    emit(outr(FN_ADC, 6'd12, 6'd3, 6'd3));
    emit(outr(FN_CARRY, 6'd11, 6'd0, 6'd0));
    emit(outr(FN_MUL_LO, 6'd7, 6'd1, 6'd6));
    emit(outr(FN_ADD, 6'd8, 6'd7, 6'd7));
    emit(outr(FN_OVF, 6'd11, 6'd0, 6'd0));
    emit(outr(FN_SUB, 6'd13, 6'd2, 6'd3));
    emit(outr(FN_OVF, 6'd11, 6'd0, 6'd0));
    emit(outr(FN_SUB, 6'd14, 6'd8, 6'd7));
    emit(outr(FN_OVF, 6'd11, 6'd0, 6'd0));
    emit(outr(FN_INC, 6'd15, 6'd13, 6'd0));
    emit(outr(FN_DEC, 6'd16, 6'd15, 6'd0));
    emit(outr(FN_MUL_HI, 6'd17, 6'd1, 6'd1));
    emit(outr(FN_AND, 6'd18, 6'd1, 6'd13));
    emit(outr(FN_OR, 6'd19, 6'd3, 6'd2));
    emit(outr(FN_XOR, 6'd20, 6'd1, 6'd3));
    emit(outr(FN_EQ, 6'd21, 6'd3, 6'd3));
    emit(outr(FN_EQ, 6'd21, 6'd3, 6'd2));
    emit(outr(FN_LT_S, 6'd22, 6'd2, 6'd3));
    emit(outr(FN_LT_U, 6'd22, 6'd2, 6'd3));
    emit(outr(FN_PASS_B, 6'd23, 6'd0, 6'd12));
    emit(enc_r(OP_OUT, FN_ADD, 1'b0, 6'd24, 1'b1, 6'h3F, 1'b1, 6'd9));
    // Dropped opcode and immediate form without load run as no-operations
    emit(enc_r(6'd12, FN_ADD, 1'b0, 6'd25, 1'b0, 6'd1, 1'b0, 6'd1));
    emit({1'b0, 6'd25, 1'b1, 24'h00_0123});
    emit(outr(FN_PASS_B, 6'd26, 6'd0, 6'd25));
  endtask

  task automatic load_shift_program();
    prog_len = 32'd0;
    emit(enc_ldi(6'd1, 1193046));
    emit(enc_ldi(6'd2, 4));
    emit(outr(FN_ADD, 6'd3, 6'd1, 6'd2));
    emit(enc_r(OP_SHIFT, 4'd0, 1'b0, 6'd4, 1'b0, 6'd3, 1'b1, 6'd8));
    emit(outr(FN_PASS_B, 6'd30, 6'd0, 6'd4));
    emit(enc_r(OP_SHIFT, 4'd1, 1'b0, 6'd5, 1'b0, 6'd4, 1'b1, 6'd3));
    emit(outr(FN_PASS_B, 6'd30, 6'd0, 6'd5));
    emit(enc_ldi(6'd6, -1000));
    emit(enc_r(OP_SHIFT, 4'd2, 1'b0, 6'd7, 1'b0, 6'd6, 1'b1, 6'd24));
    emit(outr(FN_PASS_B, 6'd30, 6'd0, 6'd7));
    emit(enc_r(OP_SHIFT, 4'd3, 1'b0, 6'd8, 1'b0, 6'd1, 1'b1, 6'd28));
    emit(outr(FN_PASS_B, 6'd30, 6'd0, 6'd8));
    emit(enc_r(OP_SHIFT, 4'd3, 1'b0, 6'd8, 1'b0, 6'd8, 1'b0, 6'd2));
    emit(outr(FN_PASS_B, 6'd30, 6'd0, 6'd8));
    emit(enc_r(OP_IN, 4'd0, 1'b0, 6'd9, 1'b0, 6'd0, 1'b0, 6'd0));
    emit(outr(FN_ADD, 6'd10, 6'd9, 6'd9));
    emit(outr(FN_ADD, 6'd10, 6'd10, 6'd10));
    emit(outr(FN_INC, 6'd10, 6'd10, 6'd0));
  endtask

  task automatic load_branch_program();
    prog_len = 32'd0;
    emit(enc_ldi(6'd1, 5));
    emit(enc_ldi(6'd2, 0));
    emit(enc_ldi(6'd3, 682));
    emit(enc_r(OP_BZ, FN_OR, 1'b1, 6'd12, 1'b0, 6'd2, 1'b0, 6'd2));
    emit(outr(FN_PASS_B, 6'd30, 6'd0, 6'd3));
    emit(outr(FN_PASS_B, 6'd30, 6'd0, 6'd3));
    emit(enc_r(OP_BZ, FN_OR, 1'b1, 6'd12, 1'b0, 6'd1, 1'b0, 6'd1));
    emit(outr(FN_PASS_B, 6'd30, 6'd0, 6'd1));
    emit(enc_r(OP_BNZ, FN_OR, 1'b1, 6'd12, 1'b0, 6'd1, 1'b0, 6'd1));
    emit(outr(FN_PASS_B, 6'd30, 6'd0, 6'd3));
    emit(outr(FN_PASS_B, 6'd30, 6'd0, 6'd3));
    emit(enc_r(OP_BNZ, FN_OR, 1'b1, 6'd8, 1'b0, 6'd2, 1'b0, 6'd2));
    emit(enc_r(OP_OUT, FN_PASS_B, 1'b0, 6'd30, 1'b0, 6'd0, 1'b1, 6'd7));
    emit(enc_r(OP_JAL, FN_ADD, 1'b0, 6'd5, 1'b1, 6'd12, 1'b0, 6'd0));
    emit(outr(FN_PASS_B, 6'd30, 6'd0, 6'd3));
    emit(outr(FN_PASS_B, 6'd30, 6'd0, 6'd3));
    emit(outr(FN_PASS_B, 6'd30, 6'd0, 6'd5));
    emit(enc_r(OP_OUT, FN_PASS_B, 1'b0, 6'd30, 1'b0, 6'd0, 1'b1, 6'd3));
  endtask

  // ####################
  // Reference model
  // ####################
  function automatic logic [31:0] sext6(input logic [5:0] f);
    return {{26{f[5]}}, f};
  endfunction

  task automatic model_run(input logic [1:0] din);
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] wv;
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] res;
    logic [31:0] shr;
    logic [31:0] mag;
    logic [31:0] mpc;
    logic [31:0] next_pc;
    logic [63:0] p;
    logic [32:0] s;
    logic [5:0]  op;
    logic [5:0]  wa;
    logic [4:0]  amt;
    logic [9:0]  last_exp;
    logic        mcarry;
    logic        movf;
    logic        nc;
    logic        nv;
    int          steps;
    for (int i = 0; i < 64; i++) begin
      mregs[i] = 32'd0;
    end
    exp_q.delete();
    mcarry = 1'b0;
    movf = 1'b0;
    mpc = 32'd0;
    last_exp = 10'd0;
    taken_count = 0;
    steps = 0;
    while (mpc[31:2] < prog_len[29:0] && steps < 1000) begin
      steps++;
      w = prog_mem[mpc[7:2]];
      wa = w[30:25];
      if (w[24]) begin
        op = w[31] ? 6'd13 : 6'd63;
      end else begin
        op = w[5:0];
        if (!(op == 6'd10 || op == 6'd11) &&
            (w[31] || !(op inside {6'd0, 6'd1, 6'd6, 6'd7, 6'd9}))) begin
          op = 6'd63;
        end
      end
      a = w[23] ? sext6(w[22:17]) : mregs[w[22:17]];
      b = w[16] ? sext6(w[15:10]) : mregs[w[15:10]];
      wv = w[31] ? sext6(wa) : mregs[wa];
      x = (op == 6'd9) ? mpc : a;
      y = (op == 6'd9) ? a : b;
      nc = mcarry;
      nv = movf;
      p = {32'd0, x} * {32'd0, y};
      case (w[9:6])
        FN_ADD: begin
          s = {1'b0, x} + {1'b0, y};
          res = s[31:0];
          nc = s[32];
          nv = (x[31] == y[31]) && (res[31] != x[31]);
        end
        FN_ADC: begin
          s = {1'b0, x} + {1'b0, y} + {32'd0, mcarry};
          res = s[31:0];
          nc = s[32];
        end
        FN_SUB: begin
          res = x - y;
          nv = (x[31] != y[31]) && (res[31] != x[31]);
        end
        FN_CARRY:  res = {31'd0, mcarry};
        FN_OVF:    res = {31'd0, movf};
        FN_INC:    res = x + 32'd1;
        FN_DEC:    res = x - 32'd1;
        FN_MUL_LO: res = p[31:0];
        FN_MUL_HI: res = p[63:32];
        FN_AND:    res = x & y;
        FN_OR:     res = x | y;
        FN_XOR:    res = x ^ y;
        FN_EQ:     res = {31'd0, x == y};
        FN_LT_S:   res = {31'd0, $signed(x) < $signed(y)};
        FN_LT_U:   res = {31'd0, x < y};
        default:   res = y;
      endcase
      amt = b[4:0];
      case (w[7:6])
        2'd0:    shr = a << amt;
        2'd1:    shr = a >> amt;
        2'd2:    shr = $signed(a) >>> amt;
        default: shr = (a >> amt) | (a << (6'd32 - {1'b0, amt}));
      endcase
      next_pc = mpc + 32'd4;
      if (op inside {6'd0, 6'd6, 6'd9, 6'd10, 6'd11}) begin
        mcarry = nc;
        movf = nv;
      end
      case (op)
        6'd0: mregs[wa] = res;
        6'd1: mregs[wa] = shr;
        6'd6: begin
          mregs[wa] = res;
          if (res[9:0] != last_exp) begin
            exp_q.push_back(res[9:0]);
            last_exp = res[9:0];
          end
        end
        6'd7: mregs[wa] = {30'd0, din};
        6'd9: begin
          mregs[wa] = mpc + 32'd4;
          next_pc = res;
          taken_count++;
        end
        6'd10, 6'd11: begin
          if ((res == 32'd0) == (op == 6'd10)) begin
            next_pc = mpc + wv;
            taken_count++;
          end
        end
        6'd13: begin
          mag = {9'd0, w[22:0]};
          mregs[wa] = w[23] ? 32'd0 - mag : mag;
        end
        default: ;
      endcase
      mpc = next_pc;
    end
  endtask

  // ####################
  // Sequencing helpers
  // ####################
  task automatic reset_dut();
    rst_n = 1'b0;
    mem_start_ready = 1'b0;
    error = 2'd0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
  endtask

  task automatic wait_out_change(input logic [9:0] prev);
    int cycles;
    cycles = 0;
    while (data_out === prev && cycles < 3000) begin
      @(negedge clk);
      cycles++;
    end
    if (data_out === prev) begin
      $display("Timeout: data_out never moved away from 0x%h", prev);
      other_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic run_program_check(input logic [1:0] din, input logic stalls);
    logic [9:0] last;
    int         base;
    random_ready = 1'b0;
    reset_dut();
    data_in = din;
    model_run(din);
    random_ready = stalls;
    base = restart_count;
    mem_start_ready = 1'b1;
    last = 10'd0;
    foreach (exp_q[i]) begin
      wait_out_change(last);
      if (timed_out) begin
        return;
      end
      check("data_out", {22'd0, data_out}, {22'd0, exp_q[i]});
      last = data_out;
    end
    // Nothing more may appear, skipped paths included
    repeat (100) begin
      @(negedge clk);
      check("data_out", {22'd0, data_out}, {22'd0, last});
    end
    restarts_seen = restart_count - base;
  endtask

  // ####################
  // Tests
  // ####################
  task automatic test_boot();
    int cycles;
    prog_len = 32'd0;
    reset_dut();
    repeat (20) begin
      @(negedge clk);
      check("command", {29'd0, command}, {29'd0, CMD_IDLE});
      check("pc", pc, 32'd0);
    end
    mem_start_ready = 1'b1;
    cycles = 0;
    while (command !== CMD_RESTART && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (command !== CMD_RESTART) begin
      $display("Timeout: no restart command after mem_start_ready");
      other_errors++;
      timed_out = 1'b1;
      return;
    end
    @(negedge clk);
    check("command", {29'd0, command}, {29'd0, CMD_IDLE});
  endtask

  task automatic test_arith();
    load_arith_program();
    run_program_check(2'd0, 1'b0);
  endtask

  task automatic test_bypass_shift();
    load_shift_program();
    run_program_check(2'd2, 1'b0);
  endtask

  task automatic test_control_flow();
    load_branch_program();
    run_program_check(2'd0, 1'b0);
    if (!timed_out) begin
      check("restart pulses", restarts_seen, taken_count + 1);
    end
  endtask

  task automatic test_stalls();
    load_arith_program();
    run_program_check(2'd0, 1'b1);
    random_ready = 1'b0;
  endtask

  task automatic test_halt();
    logic [31:0] hold_pc;
    logic [9:0]  hold_out;
    load_arith_program();
    reset_dut();
    mem_start_ready = 1'b1;
    wait_out_change(10'd0);
    if (timed_out) begin
      return;
    end
    error = 2'd1;
    repeat (2) @(negedge clk);
    hold_pc = pc;
    hold_out = data_out;
    repeat (50) begin
      @(negedge clk);
      check("pc", pc, hold_pc);
      check("data_out", {22'd0, data_out}, {22'd0, hold_out});
      check("command", {29'd0, command}, {29'd0, CMD_IDLE});
    end
  endtask

  initial begin
    rst_n = 1'b0;
    mem_start_ready = 1'b0;
    error = 2'd0;
    data_in = 2'd0;
    random_ready = 1'b0;
    prog_len = 32'd0;
    timed_out = 1'b0;
    mismatches = 0;
    other_errors = 0;
    test_boot();
    if (!timed_out) test_arith();
    if (!timed_out) test_bypass_shift();
    if (!timed_out) test_control_flow();
    if (!timed_out) test_stalls();
    if (!timed_out) test_halt();
    $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- agp32_params.svh
`ifndef AGP32_PARAMS_SVH
`define AGP32_PARAMS_SVH

// Datapath and register file
`define AGP32_XLEN 32
`define AGP32_NREGS 64
`define AGP32_RADDR_W 6

// External data ports
`define AGP32_OUT_W 10
`define AGP32_IN_W 2

// Bubble word decodes as no-operation
`define AGP32_NOP_WORD 32'd63

`define AGP32_PC_STEP 32'd4

`endif

//--- agp32_pkg.sv
`include "agp32_params.svh"

package agp32_pkg;

  // One instruction word, two decodings
  typedef union packed {
    struct packed {
      logic                       w_imm;
      logic [`AGP32_RADDR_W-1:0]  addr_w;
      logic                       is_imm;
      logic                       a_imm;
      logic [`AGP32_RADDR_W-1:0]  addr_a;
      logic                       b_imm;
      logic [`AGP32_RADDR_W-1:0]  addr_b;
      logic [3:0]                 func;
      logic [5:0]                 opcode;
    } reg_form;
    struct packed {
      logic                       load;
      logic [`AGP32_RADDR_W-1:0]  addr_w;
      logic                       is_imm;
      logic                       sign;
      logic [22:0]                magnitude;
    } imm_form;
  } instr_u;

  typedef enum logic [5:0] {
    OP_ALU   = 6'd0,
    OP_SHIFT = 6'd1,
    OP_OUT   = 6'd6,
    OP_IN    = 6'd7,
    OP_JAL   = 6'd9,
    OP_BZ    = 6'd10,
    OP_BNZ   = 6'd11,
    OP_LDI   = 6'd13,
    OP_NOP   = 6'd15
  } opcode_e;

  typedef enum logic [3:0] {
    FN_ADD, FN_ADC, FN_SUB, FN_CARRY, FN_OVF, FN_INC, FN_DEC, FN_MUL_LO,
    FN_MUL_HI, FN_AND, FN_OR, FN_XOR, FN_EQ, FN_LT_S, FN_LT_U, FN_PASS_B
  } alu_func_e;

  typedef enum logic [2:0] {
    CMD_IDLE    = 3'd0,
    CMD_RESTART = 3'd1
  } command_e;

endpackage

//--- agp32_stage_if.sv
`timescale 1ns/1ps
`include "agp32_params.svh"

interface agp32_stage_if;
  import agp32_pkg::*;

  logic                       valid;
  logic [`AGP32_XLEN-1:0]     pc;
  logic [`AGP32_XLEN-1:0]     data_a;
  logic [`AGP32_XLEN-1:0]     data_b;
  logic [`AGP32_XLEN-1:0]     data_w;
  logic [`AGP32_XLEN-1:0]     imm;
  opcode_e                    opcode;
  alu_func_e                  func;
  logic [`AGP32_RADDR_W-1:0]  addr_w;

  modport producer (
    output valid, pc, data_a, data_b, data_w, imm, opcode, func, addr_w
  );

  modport consumer (
    input valid, pc, data_a, data_b, data_w, imm, opcode, func, addr_w
  );

endinterface

//--- decode_stage.sv
`timescale 1ns/1ps
`include "agp32_params.svh"

module decode_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      advance,
  input  logic                      flush,
  input  agp32_pkg::instr_u         f_instr,
  input  logic [`AGP32_XLEN-1:0]    f_pc,
  input  logic                      f_valid,
  input  logic                      wb_en,
  input  logic [`AGP32_RADDR_W-1:0] wb_addr,
  input  logic [`AGP32_XLEN-1:0]    wb_data,
  agp32_stage_if.producer           stage
);
  import agp32_pkg::*;

  opcode_e                   opcode;
  logic [`AGP32_XLEN-1:0]    imm;
  logic [`AGP32_XLEN-1:0]    rd_a;
  logic [`AGP32_XLEN-1:0]    rd_b;
  logic [`AGP32_XLEN-1:0]    rd_w;
  logic [`AGP32_XLEN-1:0]    data_a;
  logic [`AGP32_XLEN-1:0]    data_b;
  logic [`AGP32_XLEN-1:0]    data_w;

  function automatic logic [`AGP32_XLEN-1:0] sext_field(input logic [`AGP32_RADDR_W-1:0] f);
    return {{(`AGP32_XLEN - `AGP32_RADDR_W){f[`AGP32_RADDR_W-1]}}, f};
  endfunction

  function automatic logic [`AGP32_XLEN-1:0] pick(input logic use_imm,
                                                  input logic [`AGP32_RADDR_W-1:0] addr,
                                                  input logic [`AGP32_XLEN-1:0] rd);
    logic [`AGP32_XLEN-1:0] reg_val;
    // Writeback in flight wins over the array
    reg_val = (wb_en && (wb_addr == addr)) ? wb_data : rd;
    return use_imm ? sext_field(addr) : reg_val;
  endfunction

  register_file u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .addr_a  (f_instr.reg_form.addr_a),
    .addr_b  (f_instr.reg_form.addr_b),
    .addr_w  (f_instr.reg_form.addr_w),
    .rd_a    (rd_a),
    .rd_b    (rd_b),
    .rd_w    (rd_w),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data)
  );

  // ####################
  // Field decode
  // ####################
  always_comb begin
    if (f_instr.imm_form.is_imm) begin
      opcode = f_instr.imm_form.load ? OP_LDI : OP_NOP;
    end else begin
      case (f_instr.reg_form.opcode)
        6'd10, 6'd11: opcode = opcode_e'(f_instr.reg_form.opcode);
        6'd0, 6'd1, 6'd6, 6'd7, 6'd9: begin
          opcode = f_instr.reg_form.w_imm ? OP_NOP : opcode_e'(f_instr.reg_form.opcode);
        end
        default: opcode = OP_NOP;
      endcase
    end
  end

  // Sign-magnitude immediate
  always_comb begin
    imm = {{(`AGP32_XLEN - 23){1'b0}}, f_instr.imm_form.magnitude};
    if (opcode != OP_LDI) begin
      imm = '0;
    end else if (f_instr.imm_form.sign) begin
      imm = -imm;
    end
  end

  always_comb begin
    data_a = pick(f_instr.reg_form.a_imm, f_instr.reg_form.addr_a, rd_a);
    data_b = pick(f_instr.reg_form.b_imm, f_instr.reg_form.addr_b, rd_b);
    data_w = pick(f_instr.reg_form.w_imm, f_instr.reg_form.addr_w, rd_w);
  end

  // ####################
  // Decode to execute
  // ####################
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage.valid <= 1'b0;
    end else if (advance) begin
      stage.valid <= f_valid && !flush;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      stage.opcode <= flush ? OP_NOP : opcode;
      stage.pc     <= f_pc;
      stage.data_a <= data_a;
      stage.data_b <= data_b;
      stage.data_w <= data_w;
      stage.imm    <= imm;
      stage.func   <= alu_func_e'(f_instr.reg_form.func);
      stage.addr_w <= f_instr.reg_form.addr_w;
    end
  end

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps
`include "agp32_params.svh"

module execute_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      advance,
  input  logic [`AGP32_IN_W-1:0]    data_in,
  agp32_stage_if.consumer           stage,
  output logic                      wb_en,
  output logic [`AGP32_RADDR_W-1:0] wb_addr,
  output logic [`AGP32_XLEN-1:0]    wb_data,
  output logic                      redirect,
  output logic [`AGP32_XLEN-1:0]    redirect_pc,
  output logic [`AGP32_OUT_W-1:0]   data_out
);
  import agp32_pkg::*;

  logic [`AGP32_XLEN-1:0]   alu_a;
  logic [`AGP32_XLEN-1:0]   alu_b;
  logic [`AGP32_XLEN:0]     sum;
  logic [`AGP32_XLEN-1:0]   diff;
  logic [2*`AGP32_XLEN-1:0] prod;
  logic [`AGP32_XLEN-1:0]   alu_res;
  logic [2*`AGP32_XLEN-1:0] rot;
  logic [`AGP32_XLEN-1:0]   shift_res;
  logic [4:0]               shift_sh;
  logic                     carry_flag;
  logic                     ovf_flag;
  logic                     carry_nxt;
  logic                     ovf_nxt;
  logic                     fire;
  logic                     uses_alu;
  logic                     writes_reg;
  logic                     taken;

  assign fire       = advance && stage.valid;
  assign uses_alu   = stage.opcode inside {OP_ALU, OP_OUT, OP_JAL, OP_BZ, OP_BNZ};
  assign writes_reg = stage.opcode inside {OP_ALU, OP_SHIFT, OP_OUT, OP_IN, OP_JAL, OP_LDI};

  // Jump and link adds to its own pc
  assign alu_a = (stage.opcode == OP_JAL) ? stage.pc : stage.data_a;
  assign alu_b = (stage.opcode == OP_JAL) ? stage.data_a : stage.data_b;

  assign sum  = {1'b0, alu_a} + {1'b0, alu_b} +
                {{`AGP32_XLEN{1'b0}}, (stage.func == FN_ADC) && carry_flag};
  assign diff = alu_a - alu_b;
  assign prod = {{`AGP32_XLEN{1'b0}}, alu_a} * {{`AGP32_XLEN{1'b0}}, alu_b};

  // ####################
  // ALU
  // ####################
  always_comb begin
    alu_res   = '0;
    carry_nxt = carry_flag;
    ovf_nxt   = ovf_flag;
    case (stage.func)
      FN_ADD: begin
        alu_res   = sum[`AGP32_XLEN-1:0];
        carry_nxt = sum[`AGP32_XLEN];
        ovf_nxt   = (alu_a[31] == alu_b[31]) && (sum[31] != alu_a[31]);
      end
      FN_ADC: begin
        alu_res   = sum[`AGP32_XLEN-1:0];
        carry_nxt = sum[`AGP32_XLEN];
      end
      FN_SUB: begin
        alu_res = diff;
        ovf_nxt = (alu_a[31] != alu_b[31]) && (diff[31] != alu_a[31]);
      end
      FN_CARRY:  alu_res = {{(`AGP32_XLEN-1){1'b0}}, carry_flag};
      FN_OVF:    alu_res = {{(`AGP32_XLEN-1){1'b0}}, ovf_flag};
      FN_INC:    alu_res = alu_a + 1'b1;
      FN_DEC:    alu_res = alu_a - 1'b1;
      FN_MUL_LO: alu_res = prod[`AGP32_XLEN-1:0];
      FN_MUL_HI: alu_res = prod[2*`AGP32_XLEN-1:`AGP32_XLEN];
      FN_AND:    alu_res = alu_a & alu_b;
      FN_OR:     alu_res = alu_a | alu_b;
      FN_XOR:    alu_res = alu_a ^ alu_b;
      FN_EQ:     alu_res = {{(`AGP32_XLEN-1){1'b0}}, alu_a == alu_b};
      FN_LT_S:   alu_res = {{(`AGP32_XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      FN_LT_U:   alu_res = {{(`AGP32_XLEN-1){1'b0}}, alu_a < alu_b};
      default:   alu_res = alu_b;
    endcase
  end

  // Shift amount is B mod 32
  assign shift_sh = stage.data_b[4:0];
  assign rot      = {stage.data_a, stage.data_a} >> shift_sh;

  always_comb begin
    case (stage.func[1:0])
      2'd0:    shift_res = stage.data_a << shift_sh;
      2'd1:    shift_res = stage.data_a >> shift_sh;
      2'd2:    shift_res = $signed(stage.data_a) >>> shift_sh;
      default: shift_res = rot[`AGP32_XLEN-1:0];
    endcase
  end

  // ####################
  // Writeback and branch
  // ####################
  always_comb begin
    case (stage.opcode)
      OP_SHIFT: wb_data = shift_res;
      OP_IN:    wb_data = {{(`AGP32_XLEN - `AGP32_IN_W){1'b0}}, data_in};
      OP_JAL:   wb_data = stage.pc + `AGP32_PC_STEP;
      OP_LDI:   wb_data = stage.imm;
      default:  wb_data = alu_res;
    endcase
  end

  assign wb_en   = fire && writes_reg;
  assign wb_addr = stage.addr_w;

  always_comb begin
    case (stage.opcode)
      OP_JAL:  taken = 1'b1;
      OP_BZ:   taken = (alu_res == '0);
      OP_BNZ:  taken = (alu_res != '0);
      default: taken = 1'b0;
    endcase
  end

  assign redirect    = fire && taken;
  assign redirect_pc = (stage.opcode == OP_JAL) ? alu_res : stage.pc + stage.data_w;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      carry_flag <= 1'b0;
      ovf_flag   <= 1'b0;
      data_out   <= '0;
    end else if (fire) begin
      if (uses_alu) begin
        carry_flag <= carry_nxt;
        ovf_flag   <= ovf_nxt;
      end
      if (stage.opcode == OP_OUT) begin
        data_out <= alu_res[`AGP32_OUT_W-1:0];
      end
    end
  end

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ps
`include "agp32_params.svh"

module fetch_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   advance,
  input  logic                   flush,
  input  logic                   ready,
  input  logic [`AGP32_XLEN-1:0] inst_rdata,
  input  logic                   redirect,
  input  logic [`AGP32_XLEN-1:0] redirect_pc,
  output logic [`AGP32_XLEN-1:0] pc,
  output agp32_pkg::instr_u      f_instr,
  output logic [`AGP32_XLEN-1:0] f_pc,
  output logic                   f_valid
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc      <= '0;
      f_instr <= `AGP32_NOP_WORD;
      f_valid <= 1'b0;
    end else begin
      if (redirect) begin
        pc <= redirect_pc;
      end else if (advance) begin
        pc <= pc + `AGP32_PC_STEP;
      end
      if (advance) begin
        f_instr <= flush ? `AGP32_NOP_WORD : inst_rdata;
        f_valid <= !flush;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      f_pc <= pc;
    end
  end

endmodule

//--- pipeline_control.sv
`timescale 1ns/1ps

module pipeline_control (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ready,
  input  logic                mem_start_ready,
  input  logic [1:0]          error,
  input  logic                redirect,
  output agp32_pkg::command_e command,
  output logic                advance,
  output logic                flush
);
  import agp32_pkg::*;

  typedef enum logic [2:0] {
    ST_BOOT_WAIT,
    ST_RESTART,
    ST_RESUME_WAIT,
    ST_RUN,
    ST_HALT
  } state_e;

  state_e state;

  // Pipeline moves only in run with memory ready
  assign advance = (state == ST_RUN) && ready;
  assign flush   = advance && redirect;

  // ####################
  // Sequencing
  // ####################
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_BOOT_WAIT;
      command <= CMD_IDLE;
    end else if (error != 2'd0) begin
      // Halt is sticky until reset
      state   <= ST_HALT;
      command <= CMD_IDLE;
    end else begin
      case (state)
        ST_BOOT_WAIT: begin
          if (mem_start_ready) begin
            state   <= ST_RESTART;
            command <= CMD_RESTART;
          end
        end
        ST_RESTART: begin
          // Restart command lasts this one cycle
          state   <= ST_RESUME_WAIT;
          command <= CMD_IDLE;
        end
        ST_RESUME_WAIT: begin
          if (ready) begin
            state <= ST_RUN;
          end
        end
        ST_RUN: begin
          if (flush) begin
            state   <= ST_RESTART;
            command <= CMD_RESTART;
          end
        end
        default: begin
          state <= ST_HALT;
        end
      endcase
    end
  end

endmodule

//--- register_file.sv
`timescale 1ns/1ps
`include "agp32_params.svh"

module register_file (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`AGP32_RADDR_W-1:0] addr_a,
  input  logic [`AGP32_RADDR_W-1:0] addr_b,
  input  logic [`AGP32_RADDR_W-1:0] addr_w,
  output logic [`AGP32_XLEN-1:0]    rd_a,
  output logic [`AGP32_XLEN-1:0]    rd_b,
  output logic [`AGP32_XLEN-1:0]    rd_w,
  input  logic                      wb_en,
  input  logic [`AGP32_RADDR_W-1:0] wb_addr,
  input  logic [`AGP32_XLEN-1:0]    wb_data
);

  logic [`AGP32_XLEN-1:0] regs [`AGP32_NREGS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `AGP32_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[wb_addr] <= wb_data;
    end
  end

  assign rd_a = regs[addr_a];
  assign rd_b = regs[addr_b];
  assign rd_w = regs[addr_w];

endmodule

//--- run_sim.sh
#!/bin/sh
# Build with Verilator and run; pass only if the pass message is printed
verilator --binary --timing -f agp32.f --top-module agp32_core_tb -o sim_agp32 || exit 1
out=$(./obj_dir/sim_agp32)
echo "$out"
echo "$out" | grep -q "^Simulation PASSED$" && exit 0 || exit 1

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int HALF_PERIOD_NS = 5
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

endmodule
